// File: common/pmp_cfg_pkg.sv
//////////////////////////////
// RV32 only, XLEN fixed at 32 and no 34-bit Sv32 physical space
// pmpcfg W=1/R=0 combination is not filtered
//////////////////////////////

package pmp_cfg_pkg;

    //////////////////////////////
    // Architecture constants
    //////////////////////////////

    // Register and address width
    localparam int XLEN       = 32;
    // Region count allowed by the privileged spec
    localparam int MAX_REGION = 16;
    // Bits needed for a region index
    localparam int IDX_W      = $clog2(MAX_REGION);

    //////////////////////////////
    // Configuration encodings
    //////////////////////////////

    // A field of a pmpcfg byte
    typedef enum logic [1:0] {
        OFF   = 2'd0,
        TOR   = 2'd1,
        NA4   = 2'd2,
        NAPOT = 2'd3
    } addr_match_e;

    // One pmpcfg byte, msb first
    typedef struct packed {
        logic        lock;
        logic [1:0]  rsvd;
        addr_match_e a;
        logic        x;
        logic        w;
        logic        r;
    } pmp_cfg_t;

    // Target of a CSR write port access
    typedef enum logic {
        SEL_CFG  = 1'b0,
        SEL_ADDR = 1'b1
    } cfg_sel_e;

endpackage

// File: common/pmp_acc_pkg.sv
//////////////////////////////
// Single port for fetch and data, kind tells them apart
// Only U and M privilege, no S mode
//////////////////////////////

package pmp_acc_pkg;

    // Kind of access being checked
    typedef enum logic [1:0] {
        FETCH = 2'd0,
        LOAD  = 2'd1,
        STORE = 2'd2
    } acc_kind_e;

    // Privilege, encoded as in mstatus.MPP
    typedef enum logic [1:0] {
        PRIV_U = 2'b00,
        PRIV_M = 2'b11
    } priv_e;

    // Match result handed to the permission stage
    typedef struct packed {
        logic                          hit;
        logic [pmp_cfg_pkg::IDX_W-1:0] idx;
        // Permission bits of the winning entry, zero on a miss
        logic                          lock;
        logic                          x;
        logic                          w;
        logic                          r;
        acc_kind_e                     kind;
        priv_e                         priv;
    } pmp_res_t;

endpackage

// File: common/pmp_acc_if.sv
//////////////////////////////
// valid is a single-cycle pulse, fields are held until the next one
//////////////////////////////

`timescale 1ns/10ps

interface pmp_acc_if;

    // Captured access, stable while the access is in flight
    logic                         valid;
    logic [pmp_cfg_pkg::XLEN-1:0] addr;
    pmp_acc_pkg::acc_kind_e       kind;
    pmp_acc_pkg::priv_e           priv;

    // Request capture side
    modport src (output valid, addr, kind, priv);

    // Matcher side
    modport dst (input valid, addr, kind, priv);

endinterface

// File: common/pmp_res_if.sv
//////////////////////////////
// valid is a single-cycle pulse, res is only meaningful with it
//////////////////////////////

`timescale 1ns/10ps

interface pmp_res_if;

    // Result pulse
    logic                  valid;
    // Hit, index, permissions and the access attributes
    pmp_acc_pkg::pmp_res_t res;

    // Matcher side
    modport src (output valid, res);

    // Permission and handshake side
    modport dst (input valid, res);

    // No flow control, the consumer must take every pulse

endinterface

// File: csr/pmp_csr_bank.sv
//////////////////////////////
// Write-only bank without CSR read-back
// Locks clear only on reset and writes to missing entries are dropped
//////////////////////////////

`timescale 1ns/10ps

module pmp_csr_bank #(
    parameter int NB_REGION = 16
) (
    input  logic                          aclk,
    input  logic                          arst_n_i,
    input  logic                          cfg_we_i,
    input  pmp_cfg_pkg::cfg_sel_e         cfg_sel_i,
    input  logic [pmp_cfg_pkg::IDX_W-1:0] cfg_idx_i,
    input  logic [pmp_cfg_pkg::XLEN-1:0]  cfg_wdata_i,
    output pmp_cfg_pkg::pmp_cfg_t         cfg_o  [NB_REGION],
    output logic [pmp_cfg_pkg::XLEN-1:0]  addr_o [NB_REGION]
);

    import pmp_cfg_pkg::*;

    // Incoming configuration byte with the reserved field cleared
    pmp_cfg_t wcfg;

    always_comb begin
        wcfg      = pmp_cfg_t'(cfg_wdata_i[7:0]);
        wcfg.rsvd = 2'b00;
    end

    //////////////////////////////
    // Per-entry registers
    //////////////////////////////

    for (genvar i = 0; i < NB_REGION; i++) begin : g_entry

        logic            sel;
        // Set when entry i+1 is a locked TOR and pins this address
        logic            frz;
        pmp_cfg_t        cfg_q;
        logic [XLEN-1:0] addr_q;

        // Indices past NB_REGION never select
        assign sel = cfg_we_i && (cfg_idx_i == IDX_W'(i));

        if (i < NB_REGION - 1) begin : g_frz
            assign frz = cfg_o[i+1].lock && (cfg_o[i+1].a == TOR);
        end else begin : g_last
            // Topmost entry has nothing above it
            assign frz = 1'b0;
        end

        always_ff @(posedge aclk or negedge arst_n_i) begin
            if (!arst_n_i) begin
                cfg_q  <= '0;
                addr_q <= '0;
            end else if (sel && !cfg_q.lock) begin
                // Own lock blocks both registers of the entry
                if (cfg_sel_i == SEL_CFG) begin
                    cfg_q <= wcfg;
                end else if (!frz) begin
                    addr_q <= cfg_wdata_i;
                end
            end
        end

        assign cfg_o[i]  = cfg_q;
        assign addr_o[i] = addr_q;

    end

endmodule

// File: match/pmp_region_decode.sv
//////////////////////////////
// Compares on word addresses, byte offset of the access is ignored
//////////////////////////////

`timescale 1ns/10ps

module pmp_region_decode (
    input  pmp_cfg_pkg::pmp_cfg_t        cfg_i,
    input  logic [pmp_cfg_pkg::XLEN-1:0] addr_reg_i,
    input  logic [pmp_cfg_pkg::XLEN-1:0] prev_addr_reg_i,
    input  logic [pmp_cfg_pkg::XLEN-1:0] acc_addr_i,
    output logic                         hit_o
);

    import pmp_cfg_pkg::*;

    logic [XLEN-1:0] waddr;
    logic [XLEN-1:0] ign;
    logic [XLEN-1:0] mask;
    logic [XLEN-1:0] base;

    // Access address in pmpaddr units
    assign waddr = {2'b00, acc_addr_i[XLEN-1:2]};

    // Trailing ones plus the zero above them, i.e. the NAPOT size bits
    assign ign   = addr_reg_i ^ (addr_reg_i + XLEN'(1));

    // NA4 compares every bit, NAPOT drops the size bits
    assign mask  = (cfg_i.a == NAPOT) ? ~ign : '1;
    assign base  = addr_reg_i & mask;

    always_comb begin
        case (cfg_i.a)
            // Half-open range above the previous entry
            TOR:        hit_o = (waddr >= prev_addr_reg_i) && (waddr < addr_reg_i);
            NA4, NAPOT: hit_o = (waddr & mask) == base;
            default:    hit_o = 1'b0;
        endcase
    end

endmodule

// File: match/pmp_match.sv
//////////////////////////////
// One access per cycle with the result one cycle after acc.valid
// Lowest-numbered hit wins
//////////////////////////////

`timescale 1ns/10ps

module pmp_match #(
    parameter int NB_REGION = 16
) (
    input  logic                         aclk,
    input  logic                         arst_n_i,
    input  pmp_cfg_pkg::pmp_cfg_t        cfg_i  [NB_REGION],
    input  logic [pmp_cfg_pkg::XLEN-1:0] addr_i [NB_REGION],
    pmp_acc_if.dst                       acc,
    pmp_res_if.src                       res
);

    import pmp_cfg_pkg::*;
    import pmp_acc_pkg::*;

    logic [NB_REGION-1:0] hits;
    logic                 sel_hit;
    logic [IDX_W-1:0]     sel_idx;
    pmp_cfg_t             sel_cfg;
    pmp_res_t             res_d;
    pmp_res_t             res_q;
    logic                 valid_q;

    //////////////////////////////
    // Region hit tests
    //////////////////////////////

    for (genvar i = 0; i < NB_REGION; i++) begin : g_region
        logic [XLEN-1:0] prev;

        // Entry 0 TOR starts at address zero
        if (i == 0) begin : g_first
            assign prev = '0;
        end else begin : g_next
            assign prev = addr_i[i-1];
        end

        pmp_region_decode u_dec (
            .cfg_i           (cfg_i[i]),
            .addr_reg_i      (addr_i[i]),
            .prev_addr_reg_i (prev),
            .acc_addr_i      (acc.addr),
            .hit_o           (hits[i])
        );
    end

    // Scan from the top so the lowest index is written last
    always_comb begin
        sel_hit = 1'b0;
        sel_idx = '0;
        sel_cfg = '0;
        for (int i = NB_REGION - 1; i >= 0; i--) begin
            if (hits[i]) begin
                sel_hit = 1'b1;
                sel_idx = IDX_W'(i);
                sel_cfg = cfg_i[i];
            end
        end
    end

    always_comb begin
        res_d      = '0;
        res_d.hit  = sel_hit;
        res_d.idx  = sel_idx;
        res_d.lock = sel_cfg.lock;
        res_d.x    = sel_cfg.x;
        res_d.w    = sel_cfg.w;
        res_d.r    = sel_cfg.r;
        res_d.kind = acc.kind;
        res_d.priv = acc.priv;
    end

    //////////////////////////////
    // Result register
    //////////////////////////////

    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= acc.valid;
        end
    end

    // Payload only loads with a new access
    always_ff @(posedge aclk) begin
        if (acc.valid) begin
            res_q <= res_d;
        end
    end

    assign res.valid = valid_q;
    assign res.res   = res_q;

    // A reported hit always names a region that is switched on
    a_hit_enabled : assert property (
        @(posedge aclk) disable iff (!arst_n_i)
        res.valid && res.res.hit |-> cfg_i[res.res.idx].a != OFF
    );

endmodule

// File: verilog/pmp_req_port.sv
//////////////////////////////
// Request is sampled, then launched on the following edge
// Busy until the ack has fallen, fields must stay stable meanwhile
//////////////////////////////

`timescale 1ns/10ps

module pmp_req_port (
    input  logic                         aclk,
    input  logic                         arst_n_i,
    input  logic                         acc_req_i,
    input  logic [pmp_cfg_pkg::XLEN-1:0] acc_addr_i,
    input  pmp_acc_pkg::acc_kind_e       acc_kind_i,
    input  pmp_acc_pkg::priv_e           acc_priv_i,
    input  logic                         ack_done_i,
    pmp_acc_if.src                       acc
);

    import pmp_cfg_pkg::*;
    import pmp_acc_pkg::*;

    typedef enum logic {
        IDLE = 1'b0,
        BUSY = 1'b1
    } state_e;

    state_e          state_q;
    // Sampled request, also tells BUSY the request has gone
    logic            req_q;
    logic            valid_q;
    logic [XLEN-1:0] addr_q;
    acc_kind_e       kind_q;
    priv_e           priv_q;

    //////////////////////////////
    // Idle/busy FSM
    //////////////////////////////

    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= IDLE;
            req_q   <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            req_q   <= acc_req_i;
            valid_q <= 1'b0;
            case (state_q)
                IDLE: if (req_q) begin
                    valid_q <= 1'b1;
                    state_q <= BUSY;
                end
                // Ack has dropped and the request is already low
                BUSY: if (ack_done_i && !req_q) begin
                    state_q <= IDLE;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Capture fields with the launch pulse
    always_ff @(posedge aclk) begin
        if (state_q == IDLE && req_q) begin
            addr_q <= acc_addr_i;
            kind_q <= acc_kind_i;
            priv_q <= acc_priv_i;
        end
    end

    assign acc.valid = valid_q;
    assign acc.addr  = addr_q;
    assign acc.kind  = kind_q;
    assign acc.priv  = priv_q;

    // Ack rises two edges after launch, request must hold until then
    a_req_held : assert property (
        @(posedge aclk) disable iff (!arst_n_i) valid_q |-> acc_req_i ##1 acc_req_i
    );

endmodule

// File: verilog/pmp_resp_port.sv
//////////////////////////////
// allow and fault are both low whenever the ack is low
//////////////////////////////

`timescale 1ns/10ps

module pmp_resp_port (
    input  logic                          aclk,
    input  logic                          arst_n_i,
    pmp_res_if.dst                        res,
    input  logic                          acc_req_i,
    output logic                          acc_ack_o,
    output logic                          acc_allow_o,
    output logic                          acc_fault_o,
    output logic                          acc_hit_o,
    output logic [pmp_cfg_pkg::IDX_W-1:0] acc_idx_o,
    output logic                          ack_done_o
);

    import pmp_acc_pkg::*;

    logic allow_d;

    //////////////////////////////
    // Permission rule
    //////////////////////////////

    always_comb begin
        if (!res.res.hit) begin
            // Miss, only machine mode gets through
            allow_d = (res.res.priv == PRIV_M);
        end else if (res.res.priv == PRIV_M && !res.res.lock) begin
            // Unlocked entries do not bind M mode
            allow_d = 1'b1;
        end else begin
            case (res.res.kind)
                LOAD:    allow_d = res.res.r;
                STORE:   allow_d = res.res.w;
                FETCH:   allow_d = res.res.x;
                default: allow_d = 1'b0;
            endcase
        end
    end

    //////////////////////////////
    // Four-phase acknowledge
    //////////////////////////////

    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            acc_ack_o   <= 1'b0;
            acc_allow_o <= 1'b0;
            acc_fault_o <= 1'b0;
            acc_hit_o   <= 1'b0;
            acc_idx_o   <= '0;
            ack_done_o  <= 1'b0;
        end else begin
            ack_done_o <= 1'b0;
            if (res.valid) begin
                acc_ack_o   <= 1'b1;
                acc_allow_o <= allow_d;
                acc_fault_o <= !allow_d;
                acc_hit_o   <= res.res.hit;
                acc_idx_o   <= res.res.idx;
            end else if (acc_ack_o && !acc_req_i) begin
                // Request gone, close the handshake and free the input side
                acc_ack_o   <= 1'b0;
                acc_allow_o <= 1'b0;
                acc_fault_o <= 1'b0;
                ack_done_o  <= 1'b1;
            end
        end
    end

endmodule

// File: verilog/pmp_unit.sv
//////////////////////////////
// One access in flight, ack three cycles after the request is sampled
// Configure only while no access is pending
//////////////////////////////

`timescale 1ns/10ps

module pmp_unit #(
    parameter int NB_REGION = 16
) (
    input  logic                          aclk,
    input  logic                          arst_n_i,
    // CSR write port
    input  logic                          cfg_we_i,
    input  pmp_cfg_pkg::cfg_sel_e         cfg_sel_i,
    input  logic [pmp_cfg_pkg::IDX_W-1:0] cfg_idx_i,
    input  logic [pmp_cfg_pkg::XLEN-1:0]  cfg_wdata_i,
    // Access check handshake
    input  logic                          acc_req_i,
    input  logic [pmp_cfg_pkg::XLEN-1:0]  acc_addr_i,
    input  pmp_acc_pkg::acc_kind_e        acc_kind_i,
    input  pmp_acc_pkg::priv_e            acc_priv_i,
    output logic                          acc_ack_o,
    output logic                          acc_allow_o,
    output logic                          acc_fault_o,
    output logic                          acc_hit_o,
    output logic [pmp_cfg_pkg::IDX_W-1:0] acc_idx_o
);

    import pmp_cfg_pkg::*;

    // Region count must fit the architectural limit
    if (NB_REGION < 1 || NB_REGION > MAX_REGION) begin : g_bad_nb_region
        $error("NB_REGION out of range");
    end

    pmp_cfg_t        cfg  [NB_REGION];
    logic [XLEN-1:0] addr [NB_REGION];
    // Ack falling edge, releases the input side
    logic            ack_done;

    pmp_acc_if acc_bus ();
    pmp_res_if res_bus ();

    //////////////////////////////
    // Configuration registers
    //////////////////////////////

    pmp_csr_bank #(
        .NB_REGION (NB_REGION)
    ) u_csr (
        .aclk        (aclk),
        .arst_n_i    (arst_n_i),
        .cfg_we_i    (cfg_we_i),
        .cfg_sel_i   (cfg_sel_i),
        .cfg_idx_i   (cfg_idx_i),
        .cfg_wdata_i (cfg_wdata_i),
        .cfg_o       (cfg),
        .addr_o      (addr)
    );

    //////////////////////////////
    // Access pipeline
    //////////////////////////////

    pmp_req_port u_req (
        .aclk       (aclk),
        .arst_n_i   (arst_n_i),
        .acc_req_i  (acc_req_i),
        .acc_addr_i (acc_addr_i),
        .acc_kind_i (acc_kind_i),
        .acc_priv_i (acc_priv_i),
        .ack_done_i (ack_done),
        .acc        (acc_bus.src)
    );

    pmp_match #(
        .NB_REGION (NB_REGION)
    ) u_match (
        .aclk     (aclk),
        .arst_n_i (arst_n_i),
        .cfg_i    (cfg),
        .addr_i   (addr),
        .acc      (acc_bus.dst),
        .res      (res_bus.src)
    );

    pmp_resp_port u_resp (
        .aclk        (aclk),
        .arst_n_i    (arst_n_i),
        .res         (res_bus.dst),
        .acc_req_i   (acc_req_i),
        .acc_ack_o   (acc_ack_o),
        .acc_allow_o (acc_allow_o),
        .acc_fault_o (acc_fault_o),
        .acc_hit_o   (acc_hit_o),
        .acc_idx_o   (acc_idx_o),
        .ack_done_o  (ack_done)
    );

endmodule

// File: tb/pmp_ref.svh
//////////////////////////////
// Shadow of the PMP registers, sized by the testbench NB_REGION
//////////////////////////////

`ifndef PMP_REF_SVH
`define PMP_REF_SVH

pmp_cfg_t        ref_cfg  [NB_REGION];
logic [XLEN-1:0] ref_addr [NB_REGION];

// Lock rules of the CSR bank, applied to the shadow
function automatic void ref_write(cfg_sel_e sel, int idx, logic [XLEN-1:0] data);
    if (idx >= NB_REGION || ref_cfg[idx].lock) begin
        return;
    end
    if (sel == SEL_CFG) begin
        ref_cfg[idx]      = pmp_cfg_t'(data[7:0]);
        ref_cfg[idx].rsvd = 2'b00;
    end else if (!(idx + 1 < NB_REGION && ref_cfg[idx+1].lock && ref_cfg[idx+1].a == TOR)) begin
        ref_addr[idx] = data;
    end
endfunction

// Lowest matching region and the access decision
function automatic pmp_res_t ref_check(logic [XLEN-1:0] addr, acc_kind_e kind, priv_e priv,
                                       output bit allow);
    pmp_res_t        res;
    logic [XLEN-1:0] wa;
    logic [XLEN-1:0] lo;
    int              ones;
    bit              hit;
    res  = '0;
    wa   = addr >> 2;
    for (int i = 0; i < NB_REGION && !res.hit; i++) begin
        lo   = (i == 0) ? '0 : ref_addr[i-1];
        ones = 0;
        while (ones < XLEN && ref_addr[i][ones]) begin
            ones++;
        end
        case (ref_cfg[i].a)
            TOR:     hit = (wa >= lo) && (wa < ref_addr[i]);
            NA4:     hit = (wa == ref_addr[i]);
            NAPOT:   hit = ((wa >> (ones + 1)) == (ref_addr[i] >> (ones + 1)));
            default: hit = 1'b0;
        endcase
        if (hit) begin
            res.hit  = 1'b1;
            res.idx  = IDX_W'(i);
            res.lock = ref_cfg[i].lock;
            res.x    = ref_cfg[i].x;
            res.w    = ref_cfg[i].w;
            res.r    = ref_cfg[i].r;
        end
    end
    res.kind = kind;
    res.priv = priv;
    if (!res.hit) begin
        allow = (priv == PRIV_M);
    end else if (priv == PRIV_M && !res.lock) begin
        allow = 1'b1;
    end else begin
        allow = (kind == LOAD) ? res.r : (kind == STORE) ? res.w : res.x;
    end
    return res;
endfunction

`endif

// File: tb/pmp_unit_tb.sv
//////////////////////////////
// Drives on the falling edge and stops at the first mismatch
//////////////////////////////

`timescale 1ns/10ps

module pmp_unit_tb;

    import pmp_cfg_pkg::*;
    import pmp_acc_pkg::*;

    localparam int  NB_REGION = 16;
    localparam real CLK_PER   = 4.0;
    // Upper bounds on the stimulus for the watchdog
    localparam int  N_ACC     = 400;
    localparam int  N_WR      = 300;

    // Words on both sides of each NA4 and NAPOT region edge
    localparam logic [XLEN-1:0] NA_EDGES [11] = '{
        32'h3fc, 32'h400, 32'h404, 32'h7fc, 32'h800, 32'h81c,
        32'h820, 32'hffc, 32'h1000, 32'h17fc, 32'h1800
    };

    logic                   aclk;
    logic                   arst_n_i;
    logic                   cfg_we_i;
    cfg_sel_e               cfg_sel_i;
    logic [IDX_W-1:0]       cfg_idx_i;
    logic [XLEN-1:0]        cfg_wdata_i;
    logic                   acc_req_i;
    logic [XLEN-1:0]        acc_addr_i;
    acc_kind_e              acc_kind_i;
    priv_e                  acc_priv_i;
    logic                   acc_ack_o;
    logic                   acc_allow_o;
    logic                   acc_fault_o;
    logic                   acc_hit_o;
    logic [IDX_W-1:0]       acc_idx_o;

    integer   seed     = 32'habea;
    string    test_name;
    bit       ack_seen = 1'b0;
    pmp_res_t exp_res_q [$];
    bit       exp_allow_q [$];

    `include "pmp_ref.svh"

    pmp_unit #(.NB_REGION(NB_REGION)) pmp_unit_i (.*);

    initial begin
        aclk = 1'b0;
        forever #(CLK_PER / 2) aclk = ~aclk;
    end

    // Watchdog sized from the access and write counts
    initial begin
        #((N_ACC * 10 + N_WR * 2 + 50) * CLK_PER);
        $display("Simulation timed out before the tests finished");
        $display("RESULT: FAIL");
        $fatal(1);
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    task automatic fail_now(string msg);
        $display("%s: %s", test_name, msg);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_res(pmp_res_t exp, pmp_res_t act);
        if (exp.hit !== act.hit || (exp.hit && exp.idx !== act.idx)) begin
            $display("[ERROR] %s hit/idx expected %0b/%0d actual %0b/%0d",
                     test_name, exp.hit, exp.idx, act.hit, act.idx);
            fail_now("match result differs");
        end
    endtask

    task automatic check_allow(bit exp, bit act);
        if (exp !== act) begin
            $display("[ERROR] %s allow expected %0b actual %0b", test_name, exp, act);
            fail_now("decision differs");
        end
    endtask

    // One compared result per rising edge of the ack
    always @(negedge aclk) begin
        pmp_res_t act;
        if (arst_n_i && acc_ack_o && (acc_allow_o == acc_fault_o)) begin
            fail_now("allow and fault not exclusive during ack");
        end
        if (arst_n_i && !acc_ack_o && (acc_allow_o || acc_fault_o)) begin
            fail_now("allow or fault high outside ack");
        end
        if (acc_ack_o && !ack_seen) begin
            if (exp_res_q.size() == 0) begin
                fail_now("ack with no access pending");
            end
            act     = '0;
            act.hit = acc_hit_o;
            act.idx = acc_idx_o;
            check_res(exp_res_q.pop_front(), act);
            check_allow(exp_allow_q.pop_front(), acc_allow_o);
        end
        ack_seen = acc_ack_o;
    end

    //////////////////////////////
    // Stimulus tasks
    //////////////////////////////

    task automatic apply_reset();
        @(negedge aclk);
        arst_n_i = 1'b0;
        repeat (3) @(negedge aclk);
        arst_n_i = 1'b1;
        for (int i = 0; i < NB_REGION; i++) begin
            ref_cfg[i]  = '0;
            ref_addr[i] = '0;
        end
    endtask

    task automatic write_reg(cfg_sel_e sel, int idx, logic [XLEN-1:0] data);
        @(negedge aclk);
        cfg_we_i    = 1'b1;
        cfg_sel_i   = sel;
        cfg_idx_i   = IDX_W'(idx);
        cfg_wdata_i = data;
        ref_write(sel, idx, data);
        @(negedge aclk);
        cfg_we_i = 1'b0;
    endtask

    task automatic write_entry(int idx, logic [7:0] cfg, logic [XLEN-1:0] addr);
        write_reg(SEL_ADDR, idx, addr);
        write_reg(SEL_CFG, idx, {24'h0, cfg});
    endtask

    // Full four-phase access with the ack timing checked
    task automatic run_access(logic [XLEN-1:0] addr, acc_kind_e kind, priv_e priv, int hold);
        bit allow;
        int cnt;
        exp_res_q.push_back(ref_check(addr, kind, priv, allow));
        exp_allow_q.push_back(allow);
        @(negedge aclk);
        acc_req_i  = 1'b1;
        acc_addr_i = addr;
        acc_kind_i = kind;
        acc_priv_i = priv;
        cnt = 0;
        do begin
            @(negedge aclk);
            cnt++;
        end while (!acc_ack_o && cnt < 20);
        if (cnt != 4) begin
            fail_now("ack did not rise 3 cycles after the request was sampled");
        end
        repeat (hold) begin
            @(negedge aclk);
            if (!acc_ack_o) begin
                fail_now("ack dropped while the request was still high");
            end
        end
        acc_req_i = 1'b0;
        @(negedge aclk);
        if (acc_ack_o) begin
            fail_now("ack did not fall one cycle after the request dropped");
        end
        repeat (2) @(negedge aclk);
    endtask

    function automatic logic [XLEN-1:0] rand_word(logic [XLEN-1:0] mask);
        return $random(seed) & mask;
    endfunction

    //////////////////////////////
    // Tests
    //////////////////////////////

    initial begin
        arst_n_i    = 1'b0;
        cfg_we_i    = 1'b0;
        cfg_sel_i   = SEL_CFG;
        cfg_idx_i   = '0;
        cfg_wdata_i = '0;
        acc_req_i   = 1'b0;
        acc_addr_i  = '0;
        acc_kind_i  = LOAD;
        acc_priv_i  = PRIV_M;

        test_name = "handshake";
        apply_reset();
        if (acc_ack_o || acc_allow_o || acc_fault_o) begin
            fail_now("outputs not low after reset");
        end
        run_access(32'h1000, LOAD, PRIV_U, 3);

        test_name = "na4_napot";
        apply_reset();
        // NA4 of one word and NAPOT of 8 and 512 words
        write_entry(1, 8'h17, 32'h100);
        write_entry(2, 8'h1b, 32'h203);
        write_entry(3, 8'h19, 32'h4ff);
        for (int n = 0; n < 40; n++) begin
            run_access(rand_word(32'h1fff), LOAD, PRIV_U, 0);
        end
        for (int n = 0; n < 11; n++) begin
            run_access(NA_EDGES[n], LOAD, PRIV_U, 0);
        end

        test_name = "tor_priority";
        apply_reset();
        write_entry(0, 8'h09, 32'h80);
        write_entry(1, 8'h1f, 32'h3f);
        write_entry(2, 8'h0c, 32'h300);
        for (int n = 0; n < 20; n++) begin
            run_access(rand_word(32'hfff), STORE, PRIV_U, 0);
        end

        test_name = "permissions";
        apply_reset();
        for (int p = 0; p < 8; p++) begin
            write_entry(0, 8'h18 | 8'(p), 32'hffff_ffff);
            for (int k = 0; k < 3; k++) begin
                run_access(rand_word('1), acc_kind_e'(k), PRIV_U, 0);
                run_access(rand_word('1), acc_kind_e'(k), PRIV_M, 0);
            end
        end
        write_reg(SEL_CFG, 0, 32'h0);
        run_access(32'h40, FETCH, PRIV_M, 0);
        run_access(32'h40, FETCH, PRIV_U, 0);

        test_name = "locking";
        apply_reset();
        write_entry(0, 8'h00, 32'h40);
        write_entry(1, 8'h89, 32'h100);
        run_access(32'h200, STORE, PRIV_M, 0);
        run_access(32'h200, LOAD, PRIV_M, 0);
        write_entry(1, 8'h0f, 32'h200);
        write_reg(SEL_ADDR, 0, 32'h0);
        run_access(32'h200, STORE, PRIV_M, 0);
        run_access(32'h100, FETCH, PRIV_M, 0);
        run_access(32'h80, STORE, PRIV_M, 0);
        run_access(32'h3fc, LOAD, PRIV_U, 0);

        test_name = "random_soak";
        apply_reset();
        for (int n = 0; n < NB_REGION; n++) begin
            write_entry(n, 8'(rand_word(32'h9f)), rand_word(32'hfff));
        end
        for (int n = 0; n < 200; n++) begin
            run_access(rand_word(32'h3fff), acc_kind_e'(rand_word(32'h7) % 3),
                       rand_word(32'h1) ? PRIV_M : PRIV_U, 0);
        end

        if (exp_res_q.size() == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: pmp_unit.f
+incdir+tb
common/pmp_cfg_pkg.sv
common/pmp_acc_pkg.sv
common/pmp_acc_if.sv
common/pmp_res_if.sv
csr/pmp_csr_bank.sv
match/pmp_region_decode.sv
match/pmp_match.sv
verilog/pmp_req_port.sv
verilog/pmp_resp_port.sv
verilog/pmp_unit.sv
tb/pmp_unit_tb.sv

// File: run.sh
#!/bin/sh
# Compile and run the pmp_unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing -f pmp_unit.f --top-module pmp_unit_tb -o sim_pmp_unit

out=$(./obj_dir/sim_pmp_unit) || true
echo "$out"

if echo "$out" | grep -qx "RESULT: PASS"; then
    exit 0
fi
exit 1
